// File: cache_ctrl/cache_ctrl.sv
`include "dcache_settings.svh"

module cache_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    bypass_i,
    input  dcache_pkg::core_req_t   core_req_i,
    output dcache_pkg::core_rsp_t   core_rsp_o,
    output dcache_pkg::mem_req_t    mem_req_o,
    input  dcache_pkg::mem_rsp_t    mem_rsp_i,
    output dcache_pkg::arr_req_t    arr_req_o,
    input  logic [`DC_WAYS-1:0]     victim_way_i,
    input  logic                    hit_i,
    input  logic [`DC_WAYS-1:0]     hit_way_i,
    input  logic [`DC_WORD_W-1:0]   hit_word_i,
    output logic [`DC_ADDR_W-1:0]   saved_addr_o
);

    // request as taken from the core
    typedef struct packed {
        logic                  we;
        logic [`DC_ADDR_W-1:0] addr;
        logic [`DC_WORD_W-1:0] wdata;
        logic [`DC_BE_W-1:0]   be;
    } saved_req_t;

    dcache_pkg::ctrl_state_e state_d, state_q;
    saved_req_t              req_d, req_q;
    logic [`DC_WAYS-1:0]     hit_way_d, hit_way_q;
    logic [`DC_LINE_W-1:0]   line_q;
    logic [`DC_LINE_W-1:0]   rsp_line;
    logic [`DC_WORD_W-1:0]   rsp_word;
    logic                    req_bypass;

    assign saved_addr_o = req_q.addr;

    // incoming access goes straight to memory
    assign req_bypass = bypass_i | core_req_i.addr[`DC_NC_BIT];

    // word from a refilled line or from the memory lane of a bypass load
    assign rsp_line = (state_q == dcache_pkg::REFILL_WRITE) ? line_q : mem_rsp_i.rdata;
    assign rsp_word = req_q.addr[`DC_WORD_SEL_BIT] ? rsp_line[`DC_LINE_W-1 -: `DC_WORD_W]
                                                   : rsp_line[`DC_WORD_W-1:0];

    // ------------------------------------------------------------------------
    // controller FSM
    // ------------------------------------------------------------------------
    always_comb begin
        state_d   = state_q;
        req_d     = req_q;
        hit_way_d = hit_way_q;

        core_rsp_o = '0;
        mem_req_o  = '0;
        arr_req_o  = '0;

        // array lookups follow the core address by default
        arr_req_o.index = core_req_i.addr[`DC_OFFSET_W +: `DC_INDEX_W];
        arr_req_o.tag   = core_req_i.addr[`DC_ADDR_W-1 -: `DC_TAG_W];

        // memory side always works on the saved request
        mem_req_o.addr  = req_q.addr;
        mem_req_o.wdata = req_q.wdata;
        mem_req_o.be    = req_q.be;

        case (state_q)
            dcache_pkg::IDLE: begin
                if (core_req_i.data_req) begin
                    // read the set speculatively, stores need the hit too
                    arr_req_o.req = '1;
                    req_d = {core_req_i.we, core_req_i.addr, core_req_i.wdata, core_req_i.be};
                    // loads are taken at once, stores once memory accepts them
                    core_rsp_o.data_gnt = ~core_req_i.we;
                    if (req_bypass && !core_req_i.we) begin
                        state_d = dcache_pkg::BYPASS_REQ;
                    end else begin
                        state_d = dcache_pkg::WAIT_TAG;
                    end
                end
            end

            dcache_pkg::WAIT_TAG: begin
                if (req_q.we) begin
                    // hit way kept for the array write next cycle
                    hit_way_d = hit_way_i;
                    state_d   = dcache_pkg::STORE_REQ;
                end else if (hit_i) begin
                    core_rsp_o.data_rvalid = 1'b1;
                    core_rsp_o.data_rdata  = hit_word_i;
                    state_d = dcache_pkg::IDLE;
                    // a following cached load overlaps with this answer
                    if (core_req_i.data_req && !core_req_i.we && !req_bypass) begin
                        arr_req_o.req = '1;
                        req_d = {core_req_i.we, core_req_i.addr, core_req_i.wdata,
                                 core_req_i.be};
                        core_rsp_o.data_gnt = 1'b1;
                        state_d = dcache_pkg::WAIT_TAG;
                    end
                end else begin
                    state_d = dcache_pkg::MISS_REQ;
                end
            end

            dcache_pkg::STORE_REQ: begin
                // write-through, array only on a hit
                arr_req_o.req   = hit_way_q;
                arr_req_o.we    = 1'b1;
                arr_req_o.index = req_q.addr[`DC_OFFSET_W +: `DC_INDEX_W];
                arr_req_o.tag   = req_q.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
                arr_req_o.wdata = {2{req_q.wdata}};
                arr_req_o.be    = req_q.addr[`DC_WORD_SEL_BIT] ?
                                  {req_q.be, {`DC_BE_W{1'b0}}} : {{`DC_BE_W{1'b0}}, req_q.be};
                mem_req_o.valid = 1'b1;
                mem_req_o.we    = 1'b1;
                if (mem_rsp_i.gnt) begin
                    core_rsp_o.data_gnt = 1'b1;
                    state_d = dcache_pkg::IDLE;
                end else begin
                    state_d = dcache_pkg::WAIT_GNT;
                end
            end

            // memory write still pending
            dcache_pkg::WAIT_GNT: begin
                mem_req_o.valid = 1'b1;
                mem_req_o.we    = 1'b1;
                if (mem_rsp_i.gnt) begin
                    core_rsp_o.data_gnt = 1'b1;
                    state_d = dcache_pkg::IDLE;
                end
            end

            dcache_pkg::MISS_REQ: begin
                mem_req_o.valid = 1'b1;
                mem_req_o.line  = 1'b1;
                mem_req_o.addr  = {req_q.addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
                if (mem_rsp_i.gnt) state_d = dcache_pkg::WAIT_REFILL;
            end

            dcache_pkg::WAIT_REFILL: begin
                if (mem_rsp_i.rvalid) state_d = dcache_pkg::REFILL_WRITE;
            end

            dcache_pkg::REFILL_WRITE: begin
                // whole line into the victim way, requested word back to the core
                arr_req_o.req       = victim_way_i;
                arr_req_o.we        = 1'b1;
                arr_req_o.index     = req_q.addr[`DC_OFFSET_W +: `DC_INDEX_W];
                arr_req_o.tag       = req_q.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
                arr_req_o.wdata     = line_q;
                arr_req_o.be        = '1;
                arr_req_o.set_valid = 1'b1;
                core_rsp_o.data_rvalid = 1'b1;
                core_rsp_o.data_rdata  = rsp_word;
                state_d = dcache_pkg::IDLE;
            end

            dcache_pkg::BYPASS_REQ: begin
                mem_req_o.valid = 1'b1;
                if (mem_rsp_i.gnt) state_d = dcache_pkg::WAIT_BYPASS;
            end

            dcache_pkg::WAIT_BYPASS: begin
                if (mem_rsp_i.rvalid) begin
                    core_rsp_o.data_rvalid = 1'b1;
                    core_rsp_o.data_rdata  = rsp_word;
                    state_d = dcache_pkg::IDLE;
                end
            end

            default: state_d = dcache_pkg::IDLE;
        endcase
    end

    // ------------------------------------------------------------------------
    // registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= dcache_pkg::IDLE;
            req_q     <= '0;
            hit_way_q <= '0;
        end else begin
            state_q   <= state_d;
            req_q     <= req_d;
            hit_way_q <= hit_way_d;
        end
    end

    // refill line buffer
    always_ff @(posedge clk_i) begin
        if (state_q == dcache_pkg::WAIT_REFILL && mem_rsp_i.rvalid) begin
            line_q <= mem_rsp_i.rdata;
        end
    end

endmodule

// File: cache_ctrl/way_select.sv
`include "dcache_settings.svh"

module way_select (
    input  dcache_pkg::arr_rd_t                     arr_rd_i,
    input  logic [`DC_WAYS-1:0][`DC_LINE_W-1:0]     arr_data_i,
    input  logic [`DC_ADDR_W-1:0]                   saved_addr_i,
    output logic                                    hit_o,
    output logic [`DC_WAYS-1:0]                     hit_way_o,
    output logic [`DC_WORD_W-1:0]                   hit_word_o
);

    logic [`DC_TAG_W-1:0]  saved_tag;
    logic [`DC_LINE_W-1:0] hit_line;

    assign saved_tag = saved_addr_i[`DC_ADDR_W-1 -: `DC_TAG_W];

    // one-hot hit, a tag lives in one way at most
    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit_way_o[w] = arr_rd_i.way[w].valid && (arr_rd_i.way[w].tag == saved_tag);
        end
    end

    assign hit_o = |hit_way_o;

    // and-or mux of the hit line
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit_line |= arr_data_i[w] & {`DC_LINE_W{hit_way_o[w]}};
        end
    end

    // low or high word of the line
    assign hit_word_o = saved_addr_i[`DC_WORD_SEL_BIT] ? hit_line[`DC_LINE_W-1 -: `DC_WORD_W]
                                                       : hit_line[`DC_WORD_W-1:0];

endmodule

// File: common/dcache_pkg.sv
`include "dcache_settings.svh"

package dcache_pkg;

    // controller states
    typedef enum logic [3:0] {
        IDLE,
        WAIT_TAG,
        WAIT_GNT,
        STORE_REQ,
        MISS_REQ,
        WAIT_REFILL,
        REFILL_WRITE,
        BYPASS_REQ,
        WAIT_BYPASS
    } ctrl_state_e;

    // ------------------------------------------------------------------------
    // core port
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic                  data_req;
        logic                  we;
        logic [`DC_ADDR_W-1:0] addr;
        logic [`DC_WORD_W-1:0] wdata;
        logic [`DC_BE_W-1:0]   be;
    } core_req_t;

    typedef struct packed {
        logic                  data_gnt;
        logic                  data_rvalid;
        logic [`DC_WORD_W-1:0] data_rdata;
    } core_rsp_t;

    // ------------------------------------------------------------------------
    // memory port, line refills and single words
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic                  line;
        logic [`DC_ADDR_W-1:0] addr;
        logic [`DC_WORD_W-1:0] wdata;
        logic [`DC_BE_W-1:0]   be;
    } mem_req_t;

    typedef struct packed {
        logic                  gnt;
        logic                  rvalid;
        logic [`DC_LINE_W-1:0] rdata;
    } mem_rsp_t;

    // ------------------------------------------------------------------------
    // tag and data array
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [`DC_WAYS-1:0]     req;
        logic                    we;
        logic [`DC_INDEX_W-1:0]  index;
        logic [`DC_TAG_W-1:0]    tag;
        logic [`DC_LINE_W-1:0]   wdata;
        logic [`DC_LINE_BE_W-1:0] be;
        logic                    set_valid;
    } arr_req_t;

    typedef struct packed {
        logic                 valid;
        logic [`DC_TAG_W-1:0] tag;
    } tag_entry_t;

    // one entry per way, read one cycle after the access
    typedef struct packed {
        tag_entry_t [`DC_WAYS-1:0] way;
    } arr_rd_t;

endpackage

// File: common/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// ---------------------------------------------------------------------------
// data cache geometry
// ---------------------------------------------------------------------------

// byte address and core data word
`define DC_ADDR_W 32
`define DC_WORD_W 64
`define DC_BE_W 8

// one line holds two words
`define DC_LINE_W 128
`define DC_LINE_BE_W 16

// 2-way set associative, 16 sets
`define DC_WAYS 2
`define DC_SETS 16

// address split: tag | index | byte offset
`define DC_INDEX_W 4
`define DC_OFFSET_W 4
`define DC_TAG_W 24

// offset bit that picks the upper word of a line
`define DC_WORD_SEL_BIT 3

// accesses with this address bit set never allocate
`define DC_NC_BIT 31

`endif

// File: logic/cache_array.sv
`include "dcache_settings.svh"

module cache_array (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  dcache_pkg::arr_req_t                arr_req_i,
    output dcache_pkg::arr_rd_t                 arr_rd_o,
    output logic [`DC_WAYS-1:0][`DC_LINE_W-1:0] arr_data_o,
    output logic [`DC_WAYS-1:0]                 victim_way_o
);

    logic [`DC_TAG_W-1:0]              tag_mem  [`DC_WAYS][`DC_SETS];
    logic [`DC_LINE_W-1:0]             data_mem [`DC_WAYS][`DC_SETS];
    logic [`DC_WAYS-1:0][`DC_SETS-1:0] valid_q;
    logic [`DC_SETS-1:0]               repl_q;
    logic [`DC_INDEX_W-1:0]            rd_index_q;
    logic                              rd_en;
    logic                              wr_en;

    assign rd_en = |arr_req_i.req & ~arr_req_i.we;
    assign wr_en = |arr_req_i.req & arr_req_i.we;

    // ------------------------------------------------------------------------
    // tag and data storage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (wr_en && arr_req_i.req[w]) begin
                for (int b = 0; b < `DC_LINE_BE_W; b++) begin
                    if (arr_req_i.be[b]) begin
                        data_mem[w][arr_req_i.index][b*8 +: 8] <= arr_req_i.wdata[b*8 +: 8];
                    end
                end
                // tag only changes on a refill
                if (arr_req_i.set_valid) tag_mem[w][arr_req_i.index] <= arr_req_i.tag;
            end
        end
    end

    // registered read port, all ways at once
    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                arr_rd_o.way[w].tag   <= tag_mem[w][arr_req_i.index];
                arr_rd_o.way[w].valid <= valid_q[w][arr_req_i.index];
                arr_data_o[w]         <= data_mem[w][arr_req_i.index];
            end
        end
    end

    // ------------------------------------------------------------------------
    // valid bits and replacement
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q    <= '0;
            repl_q     <= '0;
            rd_index_q <= '0;
        end else begin
            if (rd_en) rd_index_q <= arr_req_i.index;
            if (wr_en && arr_req_i.set_valid) begin
                for (int w = 0; w < `DC_WAYS; w++) begin
                    if (arr_req_i.req[w]) valid_q[w][arr_req_i.index] <= 1'b1;
                end
                // flip on every refill of the set
                repl_q[arr_req_i.index] <= ~repl_q[arr_req_i.index];
            end
        end
    end

    // victim for the set of the last lookup
    // lowest invalid way first, else the way the set's bit points at
    always_comb begin
        victim_way_o = '0;
        victim_way_o[repl_q[rd_index_q]] = 1'b1;
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[w][rd_index_q]) begin
                victim_way_o    = '0;
                victim_way_o[w] = 1'b1;
            end
        end
    end

endmodule

// File: logic/dcache_top.sv
`include "dcache_settings.svh"

module dcache_top (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  bypass_i,
    input  dcache_pkg::core_req_t core_req_i,
    output dcache_pkg::core_rsp_t core_rsp_o,
    output dcache_pkg::mem_req_t  mem_req_o,
    input  dcache_pkg::mem_rsp_t  mem_rsp_i
);

    // array side
    dcache_pkg::arr_req_t                arr_req;
    dcache_pkg::arr_rd_t                 arr_rd;
    logic [`DC_WAYS-1:0][`DC_LINE_W-1:0] arr_data;
    logic [`DC_WAYS-1:0]                 victim_way;

    // hit path back into the controller
    logic                  hit;
    logic [`DC_WAYS-1:0]   hit_way;
    logic [`DC_WORD_W-1:0] hit_word;
    logic [`DC_ADDR_W-1:0] saved_addr;

    cache_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .bypass_i     (bypass_i),
        .core_req_i   (core_req_i),
        .core_rsp_o   (core_rsp_o),
        .mem_req_o    (mem_req_o),
        .mem_rsp_i    (mem_rsp_i),
        .arr_req_o    (arr_req),
        .victim_way_i (victim_way),
        .hit_i        (hit),
        .hit_way_i    (hit_way),
        .hit_word_i   (hit_word),
        .saved_addr_o (saved_addr)
    );

    way_select u_way_sel (
        .arr_rd_i     (arr_rd),
        .arr_data_i   (arr_data),
        .saved_addr_i (saved_addr),
        .hit_o        (hit),
        .hit_way_o    (hit_way),
        .hit_word_o   (hit_word)
    );

    cache_array u_array (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .arr_req_i    (arr_req),
        .arr_rd_o     (arr_rd),
        .arr_data_o   (arr_data),
        .victim_way_o (victim_way)
    );

endmodule

// File: project.f
+incdir+common
common/dcache_pkg.sv
logic/cache_array.sv
cache_ctrl/way_select.sv
cache_ctrl/cache_ctrl.sv
logic/dcache_top.sv
tests/tb_checker.sv
tests/tb_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_top -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"

# pass only when the testbench printed its pass line
echo "$out" | grep -q "^Test OK$"

// File: tests/tb_checker.sv
`include "dcache_settings.svh"

module tb_checker (
    input logic                  clk_i,
    input logic                  rst_ni,
    input logic                  bypass_i,
    input logic                  hit_phase_i,
    input dcache_pkg::core_req_t core_req_i,
    input dcache_pkg::core_rsp_t core_rsp_i,
    input dcache_pkg::mem_req_t  mem_req_i,
    input dcache_pkg::mem_rsp_t  mem_rsp_i
);

    // expected memory contents as updated at each store grant
    logic [`DC_WORD_W-1:0] shadow [256];

    // granted loads still waiting for data
    logic [31:0] pend_addr [$];
    int          pend_cycle [$];
    logic        pend_uc [$];
    int          pend_wreads [$];

    logic [31:0]           ld_addr;
    logic [`DC_WORD_W-1:0] exp_word;
    logic [7:0]            idx;
    logic                  ld_uc;
    int                    ld_wreads;
    int                    gnt_cycle;
    int                    errors      = 0;
    int                    line_reads  = 0;
    int                    word_reads  = 0;
    int                    reads_mark  = 0;
    int                    outstanding = 0;
    int                    cycle       = 0;

    function automatic logic [7:0] word_index(input logic [31:0] addr);
        return {addr[31], addr[9:3]};
    endfunction

    function automatic logic [63:0] fill_word(input logic [7:0] i);
        return {24'hc0ffee, i, ~{24'h5a5a5a, i}};
    endfunction

    // a transparent cache returns the last value written to the word
    function automatic logic [63:0] expect_load(input logic [31:0] addr);
        return shadow[word_index(addr)];
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) shadow[i] = fill_word(8'(i));
    end

    always @(posedge clk_i) begin
        if (rst_ni) begin
            cycle++;
            // data first since a new grant may come in the same cycle
            if (core_rsp_i.data_rvalid) begin
                if (outstanding == 0) begin
                    errors++;
                    $display("at %0t: rvalid without a pending load", $time);
                end else begin
                    ld_addr   = pend_addr.pop_front();
                    gnt_cycle = pend_cycle.pop_front();
                    ld_uc     = pend_uc.pop_front();
                    ld_wreads = pend_wreads.pop_front();
                    outstanding--;
                    exp_word = expect_load(ld_addr);
                    if (core_rsp_i.data_rdata !== exp_word) begin
                        errors++;
                        $display("mismatch at %0t: data_rdata got %h expected %h (addr %h)",
                                 $time, core_rsp_i.data_rdata, exp_word, ld_addr);
                    end
                    if (hit_phase_i && cycle != gnt_cycle + 1) begin
                        errors++;
                        $display("at %0t: load hit answered %0d cycles after its grant",
                                 $time, cycle - gnt_cycle);
                    end
                    // in a run of hits the next load is taken with this answer
                    if (hit_phase_i && core_req_i.data_req && !core_req_i.we
                        && !core_rsp_i.data_gnt) begin
                        errors++;
                        $display("at %0t: waiting load not granted with the hit answer", $time);
                    end
                    // uncached loads read their word from memory
                    if (ld_uc && word_reads == ld_wreads) begin
                        errors++;
                        $display("at %0t: uncached load %h got no memory word read",
                                 $time, ld_addr);
                    end
                end
            end
            if (core_rsp_i.data_gnt) begin
                if (!core_req_i.data_req) begin
                    errors++;
                    $display("at %0t: grant without a request", $time);
                end else if (core_req_i.we) begin
                    idx = word_index(core_req_i.addr);
                    for (int b = 0; b < 8; b++) begin
                        if (core_req_i.be[b]) shadow[idx][b*8 +: 8] = core_req_i.wdata[b*8 +: 8];
                    end
                end else begin
                    pend_addr.push_back(core_req_i.addr);
                    pend_cycle.push_back(cycle);
                    pend_uc.push_back(bypass_i || core_req_i.addr[`DC_NC_BIT]);
                    pend_wreads.push_back(word_reads);
                    outstanding++;
                end
            end
            // line refills only for cacheable loads
            if (mem_req_i.valid && mem_rsp_i.gnt) begin
                if (mem_req_i.line) begin
                    line_reads++;
                    if (mem_req_i.we || bypass_i || mem_req_i.addr[`DC_NC_BIT]) begin
                        errors++;
                        $display("at %0t: line request for a bypass access or a store", $time);
                    end
                end else if (!mem_req_i.we) begin
                    word_reads++;
                    if (!bypass_i && !mem_req_i.addr[`DC_NC_BIT]) begin
                        errors++;
                        $display("at %0t: single word read for a cacheable load", $time);
                    end
                end
            end
        end
    end

    task automatic mark_reads();
        reads_mark = line_reads;
    endtask

    task automatic expect_reads(input int n, input string what);
        if (line_reads - reads_mark != n) begin
            errors++;
            $display("mismatch at %0t: line_reads got %0d expected %0d for %s",
                     $time, line_reads - reads_mark, n, what);
        end
    endtask

    task automatic final_check();
        if (outstanding != 0) begin
            errors++;
            $display("%0d loads never got their data", outstanding);
        end
    endtask

endmodule

// File: tests/tb_top.sv
`include "dcache_settings.svh"

module tb_top;

    localparam int N_RANDOM    = 200;
    // directed accesses stay well below this margin
    localparam int N_ACCESS    = N_RANDOM + 40;
    localparam int CYCLE_LIMIT = 20 * N_ACCESS + 200;

    logic clk = 1'b0;
    logic rst_n;
    logic bypass;
    logic hit_phase;

    dcache_pkg::core_req_t core_req;
    dcache_pkg::core_rsp_t core_rsp;
    dcache_pkg::mem_req_t  mem_req;
    dcache_pkg::mem_rsp_t  mem_rsp = '0;

    // memory model state
    logic [`DC_WORD_W-1:0] mem [256];
    logic [31:0]           stim_seed;
    logic [31:0]           mem_seed;
    logic [31:0]           rd_addr;
    logic                  rd_line;
    logic                  rd_pending;
    logic [7:0]            idx;
    int                    gnt_delay;
    int                    rd_delay;
    int                    cycles;

    always #2 clk = ~clk;

    dcache_top dut0 (
        .clk_i      (clk),
        .rst_ni     (rst_n),
        .bypass_i   (bypass),
        .core_req_i (core_req),
        .core_rsp_o (core_rsp),
        .mem_req_o  (mem_req),
        .mem_rsp_i  (mem_rsp)
    );

    tb_checker chk (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .bypass_i    (bypass),
        .hit_phase_i (hit_phase),
        .core_req_i  (core_req),
        .core_rsp_i  (core_rsp),
        .mem_req_i   (mem_req),
        .mem_rsp_i   (mem_rsp)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // bit 31 keeps the uncacheable words apart from the cached ones
    function automatic logic [7:0] word_index(input logic [31:0] addr);
        return {addr[31], addr[9:3]};
    endfunction

    function automatic logic [63:0] fill_word(input logic [7:0] i);
        return {24'hc0ffee, i, ~{24'h5a5a5a, i}};
    endfunction

    // ------------------------------------------------------------------------
    // memory model, random grant and read delays
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        mem_rsp.gnt    = 1'b0;
        mem_rsp.rvalid = 1'b0;
        if (rd_pending) begin
            if (rd_delay == 0) begin
                idx = word_index(rd_addr);
                mem_rsp.rvalid = 1'b1;
                if (rd_line) begin
                    mem_rsp.rdata = {mem[idx + 8'd1], mem[idx]};
                end else if (rd_addr[3]) begin
                    mem_rsp.rdata = {mem[idx], 64'h0};
                end else begin
                    mem_rsp.rdata = {64'h0, mem[idx]};
                end
                rd_pending = 1'b0;
            end else begin
                rd_delay--;
            end
        end else if (rst_n && mem_req.valid) begin
            if (gnt_delay == 0) begin
                mem_rsp.gnt = 1'b1;
                if (mem_req.we) begin
                    idx = word_index(mem_req.addr);
                    for (int b = 0; b < 8; b++) begin
                        if (mem_req.be[b]) mem[idx][b*8 +: 8] = mem_req.wdata[b*8 +: 8];
                    end
                end else begin
                    rd_pending = 1'b1;
                    rd_addr    = mem_req.addr;
                    rd_line    = mem_req.line;
                    mem_seed   = lcg_next(mem_seed);
                    rd_delay   = int'(mem_seed[17:16]);
                end
                // delay for the next request
                mem_seed  = lcg_next(mem_seed);
                gnt_delay = int'(mem_seed[19:18]);
            end else begin
                gnt_delay--;
            end
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    // called on a falling edge, holds the request until the grant
    task automatic access(input logic we, input logic [31:0] addr,
                          input logic [63:0] wdata, input logic [7:0] be);
        core_req.data_req = 1'b1;
        core_req.we       = we;
        core_req.addr     = addr;
        core_req.wdata    = wdata;
        core_req.be       = be;
        #1;
        while (!core_rsp.data_gnt) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        core_req.data_req = 1'b0;
    endtask

    task automatic load(input logic [31:0] addr);
        access(1'b0, addr, 64'h0, 8'h0);
    endtask

    task automatic wait_loads_done();
        while (chk.outstanding != 0) @(negedge clk);
    endtask

    task automatic random_access();
        logic [31:0] r0;
        logic [31:0] r1;
        stim_seed = lcg_next(stim_seed);
        r0        = stim_seed;
        stim_seed = lcg_next(stim_seed);
        r1        = stim_seed;
        // 64 words, about half of them stores
        access(r0[24], {23'd0, r0[21:16], 3'd0}, {r1, r0 ^ r1}, r1[31:24]);
    endtask

    // run length limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("errors: %0d, memory line reads: %0d", chk.errors, chk.line_reads);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        core_req   = '0;
        bypass     = 1'b0;
        hit_phase  = 1'b0;
        rst_n      = 1'b0;
        stim_seed  = 32'h8212;
        mem_seed   = ~32'h8212;
        rd_pending = 1'b0;
        rd_addr    = '0;
        rd_line    = 1'b0;
        gnt_delay  = 0;
        rd_delay   = 0;
        cycles     = 0;
        for (int i = 0; i < 256; i++) mem[i] = fill_word(8'(i));
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // one miss, then the line stays resident
        chk.mark_reads();
        load(32'h50);
        load(32'h58);
        load(32'h50);
        wait_loads_done();
        chk.expect_reads(1, "line 0x50 after reloads");

        // store hit with partial byte enables, then read back
        access(1'b1, 32'h58, 64'h1122_3344_5566_7788, 8'h0f);
        load(32'h58);
        wait_loads_done();
        chk.expect_reads(1, "line 0x50 after store hit");

        // back-to-back hits, one cycle from grant to data
        hit_phase = 1'b1;
        load(32'h50);
        load(32'h58);
        load(32'h50);
        load(32'h58);
        wait_loads_done();
        hit_phase = 1'b0;

        // three lines in set 0, the third evicts the first
        chk.mark_reads();
        load(32'h000);
        load(32'h100);
        load(32'h200);
        wait_loads_done();
        chk.expect_reads(3, "set 0 fill");
        load(32'h100);
        wait_loads_done();
        chk.expect_reads(3, "resident line 0x100");
        load(32'h000);
        wait_loads_done();
        chk.expect_reads(4, "evicted line 0x000");

        // bypass mode, including a cached line
        bypass = 1'b1;
        load(32'h60);
        access(1'b1, 32'h60, 64'hdead_beef_0bad_f00d, 8'hff);
        load(32'h60);
        load(32'h50);
        access(1'b1, 32'h50, 64'h0123_4567_89ab_cdef, 8'hf0);
        wait_loads_done();
        bypass = 1'b0;
        load(32'h50);

        // uncacheable region
        load(32'h8000_0048);
        access(1'b1, 32'h8000_0048, 64'h5555_aaaa_3333_cccc, 8'h3c);
        load(32'h8000_0048);
        wait_loads_done();

        repeat (N_RANDOM) random_access();
        wait_loads_done();
        repeat (4) @(negedge clk);
        chk.final_check();

        $display("errors: %0d, memory line reads: %0d", chk.errors, chk.line_reads);
        if (chk.errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
